// File: all.f
nr_sync_pkg.sv
frame_sync_ctrl.sv
symbol_timer.sv
pss_gate.sv
symbol_tagger.sv
nr_frame_sync_top.sv
tb_clock_gen.sv
tb_nr_frame_sync.sv

// File: Bender.yml
package:
  name: nr_frame_sync

sources:
  - files:
      - nr_sync_pkg.sv
      - frame_sync_ctrl.sv
      - symbol_timer.sv
      - pss_gate.sv
      - symbol_tagger.sv
      - nr_frame_sync_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_nr_frame_sync.sv

// File: tb_nr_frame_sync.sv
`timescale 1ns/10ps
`default_nettype none

module tb_nr_frame_sync;
    import nr_sync_pkg::*;

    localparam int NUM_TESTS    = 4;
    localparam int RESET_CYCLES = 10;
    localparam int SSB2_ON_TIME = 0;
    localparam int SSB2_LATE    = 1;
    localparam int SSB2_NONE    = 2;
    localparam int LATE_OFFSET  = 6;
    // samples after the expected second SSB, enough to see the PSS mode fall back
    localparam int TAIL_LEN     = 220;

    typedef struct {
        string      name;
        int         pss_idx;
        logic [1:0] nid;
        logic [1:0] ibar;
        int         ibar_dly;
        int         ssb2;
    } test_t;

    test_t tests[NUM_TESTS];

    logic        clk;
    logic        reset_n;
    logic        restart;
    iq_sample_t  in_data;
    logic        in_valid;
    logic [1:0]  in_nid;
    logic        in_nid_valid;
    logic [2:0]  in_ibar;
    logic        in_ibar_valid;
    out_beat_t   out_beat;
    logic        out_valid;
    pss_mode_e   out_mode;
    logic [1:0]  out_nid;
    logic        out_sym_start;
    logic        out_ssb_start;

    // reference model state
    int          m_sym;
    int          m_cp;
    int          m_cnt;
    int          m_sf;
    int          m_sfn;
    int          m_state;
    int          m_exp_ssb;
    logic        m_found;
    logic        m_prev_last;
    pss_mode_e   m_mode;
    int          m_timer;
    logic [1:0]  m_nid;

    // model results of the last few samples, indexed by sample modulo 4
    out_beat_t   hist_beat[4];
    logic        hist_valid[4];
    logic        hist_start[4];
    logic        hist_ssb[4];
    pss_mode_e   hist_mode[4];
    logic [1:0]  hist_nid[4];

    string       cur_name;
    int          cur_sample;
    int          err_cnt = 0;
    int          failed_tests = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    tb_clock_gen #(.HALF_PERIOD(4), .RESET_CYCLES(RESET_CYCLES)) clock_gen_inst (
        .restart_i (restart),
        .clk_o     (clk),
        .reset_no  (reset_n)
    );

    nr_frame_sync_top nr_frame_sync_top_inst (
        .clk_i              (clk),
        .reset_ni           (reset_n),
        .s_data_i           (in_data),
        .s_valid_i          (in_valid),
        .n_id_2_i           (in_nid),
        .n_id_2_valid_i     (in_nid_valid),
        .ibar_i             (in_ibar),
        .ibar_valid_i       (in_ibar_valid),
        .m_beat_o           (out_beat),
        .m_valid_o          (out_valid),
        .pss_mode_o         (out_mode),
        .requested_n_id_2_o (out_nid),
        .symbol_start_o     (out_sym_start),
        .ssb_start_o        (out_ssb_start)
    );

    task automatic check_beat(input out_beat_t exp, input out_beat_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s beat at sample %0d: expected %h, actual %h",
                     cur_name, cur_sample, exp, act);
        end
    endtask

    task automatic check_mode(input pss_mode_e exp, input pss_mode_e act);
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s pss_mode at sample %0d: expected %0d, actual %0d",
                     cur_name, cur_sample, exp, act);
        end
    endtask

    task automatic check_nid(input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s requested_n_id_2 at sample %0d: expected %0d, actual %0d",
                     cur_name, cur_sample, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s %s at sample %0d: expected %b, actual %b",
                     cur_name, what, cur_sample, exp, act);
        end
    endtask

    task automatic drive_idle();
        in_data       = '0;
        in_valid      = 1'b0;
        in_nid        = '0;
        in_nid_valid  = 1'b0;
        in_ibar       = '0;
        in_ibar_valid = 1'b0;
    endtask

    task automatic model_reset();
        m_sym       = 0;
        m_cp        = CP2_LEN;
        m_cnt       = 0;
        m_sf        = 0;
        m_sfn       = 0;
        m_state     = 0;
        m_exp_ssb   = 0;
        m_found     = 1'b0;
        m_prev_last = 1'b0;
        m_mode      = SEARCH;
        m_timer     = 0;
        m_nid       = '0;
    endtask

    // predicts the outputs for sample k and moves the model one valid sample on
    task automatic model_step(input int k, input iq_sample_t data, input logic pulse,
                              input logic [1:0] nid, input logic ib_valid,
                              input logic [1:0] ib);
        int   slot;
        int   lbl;
        int   sf_step;
        int   adv;
        logic sym_end;
        logic acquire;
        logic apply;
        logic hit;
        logic lost;
        logic gate;
        slot    = k % 4;
        sym_end = (m_cnt == FFT_LEN + m_cp - 1);
        acquire = (m_state == 0) && pulse;
        apply   = (m_state == 1) && ib_valid;
        hit     = (m_state == 2) && pulse && !m_found &&
                  (k >= m_exp_ssb - SSB_TOL) && (k <= m_exp_ssb + SSB_TOL);
        lost    = (m_state == 2) && !m_found && (k == m_exp_ssb + SSB_TOL + 1);
        gate    = (m_state != 0) && !lost;
        hist_beat[slot]  = '{data: data,
                             tag: '{sfn: 10'(m_sfn), subframe: 5'(m_sf),
                                    symbol: 4'(m_sym), cp_len: 3'(m_cp)},
                             last: sym_end};
        hist_valid[slot] = gate;
        hist_start[slot] = gate && m_prev_last;
        hist_ssb[slot]   = acquire || ((m_state == 1) && pulse) || hit;
        if (gate) begin
            m_prev_last = sym_end;
        end
        if (hit) begin
            m_found = 1'b1;
        end
        if ((m_state == 2) && (k == m_exp_ssb + SSB_TOL + 1)) begin
            m_exp_ssb = m_exp_ssb + SSB_PERIOD_SAMPLES;
            m_found   = 1'b0;
        end
        if (lost) begin
            m_state = 0;
        end else if (acquire) begin
            m_state   = 1;
            m_exp_ssb = k + SSB_PERIOD_SAMPLES;
            m_found   = 1'b0;
        end else if (apply) begin
            m_state = 2;
        end
        // acquisition labels the pulse sample as sample 0 of symbol 3
        if (acquire) begin
            m_sym = 3;
            m_cp  = CP2_LEN;
            m_cnt = 1;
        end else begin
            // ibar 0 to 3 moves the labels on by 0, 6, 14 or 20 symbols
            case (ib)
                2'd0: adv = 0;
                2'd1: adv = 6;
                2'd2: adv = 14;
                default: adv = 20;
            endcase
            m_cnt   = sym_end ? 0 : m_cnt + 1;
            lbl     = m_sym + (sym_end ? 1 : 0) + (apply ? adv : 0);
            sf_step = 0;
            while (lbl >= SYM_PER_SF) begin
                lbl     = lbl - SYM_PER_SF;
                sf_step = sf_step + 1;
            end
            m_sym = lbl;
            m_sf  = m_sf + sf_step;
            if (m_sf >= SF_PER_FRAME) begin
                m_sf  = m_sf - SF_PER_FRAME;
                m_sfn = (m_sfn + 1) % SFN_MAX;
            end
            if (sym_end) begin
                m_cp = ((m_sym == 0) || (m_sym == 7)) ? CP1_LEN : CP2_LEN;
            end
        end
        case (m_mode)
            SEARCH: begin
                if (pulse) begin
                    m_mode  = PAUSE;
                    m_timer = 0;
                end
            end
            PAUSE: begin
                if (m_timer > SSB_PERIOD_SAMPLES - PSS_EARLY) begin
                    m_mode = FIND;
                end
                m_timer = m_timer + 1;
            end
            default: begin
                if (pulse) begin
                    m_mode  = PAUSE;
                    m_timer = 0;
                end else if (m_timer > SSB_PERIOD_SAMPLES + PSS_LATE) begin
                    m_mode = SEARCH;
                end else begin
                    m_timer = m_timer + 1;
                end
            end
        endcase
        hist_mode[slot] = m_mode;
        if (pulse) begin
            m_nid = nid;
        end
        hist_nid[slot] = m_nid;
    endtask

    // beats and the mode lag the input by 2 samples, the registered pulses by 1
    task automatic check_outputs(input int k);
        int s2;
        int s1;
        s2 = (k - 2) % 4;
        s1 = (k - 1) % 4;
        cur_sample = k - 2;
        check_flag("m_valid", hist_valid[s2], out_valid);
        if (hist_valid[s2]) begin
            check_beat(hist_beat[s2], out_beat);
        end
        check_flag("symbol_start", hist_start[s2], out_sym_start);
        check_mode(hist_mode[s2], out_mode);
        cur_sample = k - 1;
        check_flag("ssb_start", hist_ssb[s1], out_ssb_start);
        check_nid(hist_nid[s1], out_nid);
    endtask

    task automatic run_test(input int t);
        int         len;
        int         ibar_idx;
        int         ssb2_idx;
        int         errs_before;
        logic       pulse;
        iq_sample_t data;
        len         = tests[t].pss_idx + SSB_PERIOD_SAMPLES + TAIL_LEN;
        ibar_idx    = tests[t].pss_idx + tests[t].ibar_dly;
        ssb2_idx    = -1;
        cur_name    = tests[t].name;
        errs_before = err_cnt;
        if (tests[t].ssb2 == SSB2_ON_TIME) begin
            ssb2_idx = tests[t].pss_idx + SSB_PERIOD_SAMPLES;
        end else if (tests[t].ssb2 == SSB2_LATE) begin
            ssb2_idx = tests[t].pss_idx + SSB_PERIOD_SAMPLES + LATE_OFFSET;
        end
        @(posedge clk);
        #1;
        restart = 1'b1;
        @(posedge clk);
        #1;
        restart = 1'b0;
        @(posedge reset_n);
        model_reset();
        for (int k = 0; k < len; k++) begin
            @(posedge clk);
            #1;
            if (k >= 2) begin
                check_outputs(k);
            end
            data          = $urandom;
            pulse         = (k == tests[t].pss_idx) || (k == ssb2_idx);
            in_data       = data;
            in_valid      = 1'b1;
            in_nid        = tests[t].nid;
            in_nid_valid  = pulse;
            in_ibar       = {1'b0, tests[t].ibar};
            in_ibar_valid = (k == ibar_idx);
            model_step(k, data, pulse, tests[t].nid, k == ibar_idx, tests[t].ibar);
        end
        @(posedge clk);
        #1;
        drive_idle();
        if (err_cnt != errs_before) begin
            failed_tests++;
        end
        $display("%s: %0d samples, %0d mismatches", cur_name, len, err_cnt - errs_before);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: the run did not end within %0d clock cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h9f2b));
        restart = 1'b0;
        drive_idle();
        tests[0] = '{name: "ibar0_on_time", pss_idx: 300, nid: 2'd1, ibar: 2'd0,
                     ibar_dly: 100, ssb2: SSB2_ON_TIME};
        tests[1] = '{name: "ibar1_late", pss_idx: 1200, nid: 2'd2, ibar: 2'd1,
                     ibar_dly: 150, ssb2: SSB2_LATE};
        tests[2] = '{name: "ibar2_missing", pss_idx: 450, nid: 2'd0, ibar: 2'd2,
                     ibar_dly: 90, ssb2: SSB2_NONE};
        tests[3] = '{name: "ibar3_on_time", pss_idx: 700, nid: 2'd3, ibar: 2'd3,
                     ibar_dly: 120, ssb2: SSB2_ON_TIME};
        // each test also spends a few cycles on its own reset
        cycle_limit = 200;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycle_limit += tests[t].pss_idx + SSB_PERIOD_SAMPLES + TAIL_LEN + RESET_CYCLES + 4;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, failing tests %0d, mismatches %0d",
                 NUM_TESTS, failed_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 10
) (
    input  wire  restart_i,
    output logic clk_o,
    output logic reset_no
);
    int   low_cnt;
    logic restart_seen;

    initial begin
        clk_o    = 1'b0;
        reset_no = 1'b0;
        low_cnt  = 0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset moves 1 ns after the edge, like the other DUT inputs
    always @(posedge clk_o) begin
        restart_seen = restart_i;
        #1;
        if (restart_seen) begin
            reset_no = 1'b0;
            low_cnt  = 0;
        end else if (!reset_no) begin
            low_cnt = low_cnt + 1;
            if (low_cnt == RESET_CYCLES) begin
                reset_no = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: nr_frame_sync_top.sv
`timescale 1ns/10ps
`default_nettype none

module nr_frame_sync_top (
    input  wire                          clk_i,
    input  wire                          reset_ni,
    input  wire nr_sync_pkg::iq_sample_t s_data_i,
    input  wire                          s_valid_i,
    input  wire  [1:0]                   n_id_2_i,
    input  wire                          n_id_2_valid_i,
    input  wire  [2:0]                   ibar_i,
    input  wire                          ibar_valid_i,
    output nr_sync_pkg::out_beat_t       m_beat_o,
    output logic                         m_valid_o,
    output nr_sync_pkg::pss_mode_e       pss_mode_o,
    output logic [1:0]                   requested_n_id_2_o,
    output logic                         symbol_start_o,
    output logic                         ssb_start_o
);
    import nr_sync_pkg::*;

    timer_cmd_t  timer_cmd;
    symbol_tag_t tag;
    logic [7:0]  sample_cnt;
    logic        sym_end;
    logic        ssb_due;
    logic        gate;
    sync_state_e sync_state;

    frame_sync_ctrl frame_sync_ctrl_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_2_valid_i (n_id_2_valid_i),
        .ibar_i         (ibar_i[1:0]),
        .ibar_valid_i   (ibar_valid_i),
        .sym_end_i      (sym_end),
        .ssb_due_i      (ssb_due),
        .sample_cnt_i   (sample_cnt),
        .cmd_o          (timer_cmd),
        .gate_o         (gate),
        .ssb_start_o    (ssb_start_o),
        .state_o        (sync_state)
    );

    symbol_timer symbol_timer_inst (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .valid_i      (s_valid_i),
        .cmd_i        (timer_cmd),
        .tag_o        (tag),
        .sample_cnt_o (sample_cnt),
        .sym_end_o    (sym_end),
        .ssb_due_o    (ssb_due)
    );

    pss_gate pss_gate_inst (
        .clk_i              (clk_i),
        .reset_ni           (reset_ni),
        .valid_i            (s_valid_i),
        .n_id_2_i           (n_id_2_i),
        .n_id_2_valid_i     (n_id_2_valid_i),
        .pss_mode_o         (pss_mode_o),
        .requested_n_id_2_o (requested_n_id_2_o)
    );

    symbol_tagger symbol_tagger_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .data_i         (s_data_i),
        .valid_i        (s_valid_i),
        .gate_i         (gate),
        .tag_i          (tag),
        .sym_end_i      (sym_end),
        .beat_o         (m_beat_o),
        .valid_o        (m_valid_o),
        .symbol_start_o (symbol_start_o)
    );

    // case A carries at most four SSBs per burst, so the index top bit stays clear
    ibar_case_a_a : assert property (@(posedge clk_i) disable iff (!reset_ni)
        (ibar_valid_i && (sync_state == WAIT_FOR_IBAR)) |-> !ibar_i[2]);

endmodule

`default_nettype wire

// File: symbol_tagger.sv
`timescale 1ns/10ps
`default_nettype none

module symbol_tagger (
    input  wire                          clk_i,
    input  wire                          reset_ni,
    input  wire nr_sync_pkg::iq_sample_t data_i,
    input  wire                          valid_i,
    input  wire                          gate_i,
    input  wire nr_sync_pkg::symbol_tag_t tag_i,
    input  wire                          sym_end_i,
    output nr_sync_pkg::out_beat_t       beat_o,
    output logic                         valid_o,
    output logic                         symbol_start_o
);
    import nr_sync_pkg::*;

    out_beat_t s1_beat;
    logic      s1_valid;
    // last flag of the previous beat that went out
    logic      last_seen_q;

    // the tag is captured with the sample, before the timer moves on
    always_ff @(posedge clk_i) begin
        s1_beat <= '{data: data_i, tag: tag_i, last: sym_end_i};
        beat_o  <= s1_beat;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s1_valid       <= 1'b0;
            valid_o        <= 1'b0;
            symbol_start_o <= 1'b0;
            last_seen_q    <= 1'b0;
        end else begin
            s1_valid       <= valid_i && gate_i;
            valid_o        <= s1_valid;
            symbol_start_o <= s1_valid && last_seen_q;
            if (s1_valid) begin
                last_seen_q <= s1_beat.last;
            end
        end
    end

endmodule

`default_nettype wire

// File: pss_gate.sv
`timescale 1ns/10ps
`default_nettype none

module pss_gate (
    input  wire                       clk_i,
    input  wire                       reset_ni,
    input  wire                       valid_i,
    input  wire  [1:0]                n_id_2_i,
    input  wire                       n_id_2_valid_i,
    output nr_sync_pkg::pss_mode_e    pss_mode_o,
    output logic [1:0]                requested_n_id_2_o
);
    import nr_sync_pkg::*;

    pss_mode_e mode_q;
    // valid samples since the last detected PSS
    logic [$clog2(SSB_PERIOD_SAMPLES + PSS_LATE + 2)-1:0] timer_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            mode_q  <= SEARCH;
            timer_q <= '0;
        end else begin
            case (mode_q)
                SEARCH: begin
                    if (n_id_2_valid_i) begin
                        mode_q  <= PAUSE;
                        timer_q <= '0;
                    end
                end
                PAUSE: begin
                    if (int'(timer_q) > SSB_PERIOD_SAMPLES - PSS_EARLY) begin
                        mode_q <= FIND;
                    end
                    if (valid_i) begin
                        timer_q <= timer_q + 1'b1;
                    end
                end
                FIND: begin
                    if (n_id_2_valid_i) begin
                        mode_q  <= PAUSE;
                        timer_q <= '0;
                    end else if (int'(timer_q) > SSB_PERIOD_SAMPLES + PSS_LATE) begin
                        // no PSS near the expected position, search all N_id_2 again
                        mode_q <= SEARCH;
                    end else if (valid_i) begin
                        timer_q <= timer_q + 1'b1;
                    end
                end
                default: begin
                    mode_q <= SEARCH;
                end
            endcase
        end
    end

    // the detector sees the mode one cycle late
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pss_mode_o <= SEARCH;
        end else begin
            pss_mode_o <= mode_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            requested_n_id_2_o <= '0;
        end else if (n_id_2_valid_i) begin
            requested_n_id_2_o <= n_id_2_i;
        end
    end

endmodule

`default_nettype wire

// File: symbol_timer.sv
`timescale 1ns/10ps
`default_nettype none

module symbol_timer (
    input  wire                       clk_i,
    input  wire                       reset_ni,
    input  wire                       valid_i,
    input  wire nr_sync_pkg::timer_cmd_t cmd_i,
    output nr_sync_pkg::symbol_tag_t  tag_o,
    output logic [7:0]                sample_cnt_o,
    output logic                      sym_end_o,
    output logic                      ssb_due_o
);
    import nr_sync_pkg::*;

    symbol_tag_t tag_q;
    symbol_tag_t tag_nxt;
    logic [7:0]  sample_cnt_q;
    logic [8:0]  ssb_cnt_q;
    logic [7:0]  sym_len;
    logic        apply;
    logic [2:0]  sym_add;
    logic [4:0]  sym_sum;
    logic        sym_wrap;
    logic [1:0]  sf_add;
    logic [5:0]  sf_sum;
    logic        sf_wrap;

    assign sym_len   = 8'(FFT_LEN) + {5'd0, tag_q.cp_len};
    assign sym_end_o = valid_i && (sample_cnt_q == sym_len - 8'd1);
    assign ssb_due_o = ssb_cnt_q == 9'(SYMS_BTWN_SSB - 1);

    assign tag_o        = tag_q;
    assign sample_cnt_o = sample_cnt_q;

    // symbol end steps the labels by one, the ibar advance by 6, 14 or 20
    // symbols, and both can land in the same cycle
    assign apply    = cmd_i.ibar_apply;
    assign sym_add  = {2'b00, sym_end_o} + ((apply && cmd_i.ibar_adv[0]) ? 3'd6 : 3'd0);
    assign sym_sum  = {1'b0, tag_q.symbol} + {2'b00, sym_add};
    assign sym_wrap = sym_sum >= 5'(SYM_PER_SF);
    assign sf_add   = {1'b0, apply && cmd_i.ibar_adv[1]} + {1'b0, sym_wrap};
    assign sf_sum   = {1'b0, tag_q.subframe} + {4'd0, sf_add};
    assign sf_wrap  = sf_sum >= 6'(SF_PER_FRAME);

    always_comb begin
        tag_nxt = tag_q;
        if (sym_wrap) begin
            tag_nxt.symbol = 4'(sym_sum - 5'(SYM_PER_SF));
        end else begin
            tag_nxt.symbol = sym_sum[3:0];
        end
        if (sf_wrap) begin
            tag_nxt.subframe = 5'(sf_sum - 6'(SF_PER_FRAME));
            if (tag_q.sfn == 10'(SFN_MAX - 1)) begin
                tag_nxt.sfn = '0;
            end else begin
                tag_nxt.sfn = tag_q.sfn + 10'd1;
            end
        end else begin
            tag_nxt.subframe = sf_sum[4:0];
        end
        // the ibar advance relabels the running symbol but keeps its length
        if (sym_end_o) begin
            if ((tag_nxt.symbol == 4'd0) || (tag_nxt.symbol == 4'd7)) begin
                tag_nxt.cp_len = 3'(CP1_LEN);
            end else begin
                tag_nxt.cp_len = 3'(CP2_LEN);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            tag_q        <= '{sfn: '0, subframe: '0, symbol: '0, cp_len: 3'(CP2_LEN)};
            sample_cnt_q <= '0;
            ssb_cnt_q    <= '0;
        end else if (cmd_i.acquire) begin
            // the pulse sample was sample 0, assume ibar 0 (symbol 3) for now
            tag_q.symbol <= 4'd3;
            tag_q.cp_len <= 3'(CP2_LEN);
            sample_cnt_q <= 8'd1;
            ssb_cnt_q    <= '0;
        end else begin
            tag_q <= tag_nxt;
            if (valid_i) begin
                sample_cnt_q <= sym_end_o ? 8'd0 : sample_cnt_q + 8'd1;
            end
            if (sym_end_o) begin
                ssb_cnt_q <= ssb_due_o ? 9'd0 : ssb_cnt_q + 9'd1;
            end
        end
    end

    sample_range_a : assert property (@(posedge clk_i) disable iff (!reset_ni)
        sample_cnt_q < sym_len);

endmodule

`default_nettype wire

// File: frame_sync_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module frame_sync_ctrl (
    input  wire                       clk_i,
    input  wire                       reset_ni,
    input  wire                       n_id_2_valid_i,
    input  wire  [1:0]                ibar_i,
    input  wire                       ibar_valid_i,
    input  wire                       sym_end_i,
    input  wire                       ssb_due_i,
    input  wire  [7:0]                sample_cnt_i,
    output nr_sync_pkg::timer_cmd_t   cmd_o,
    output logic                      gate_o,
    output logic                      ssb_start_o,
    output nr_sync_pkg::sync_state_e  state_o
);
    import nr_sync_pkg::*;

    sync_state_e state_q;
    logic        find_win_q;
    logic        crossed_q;
    logic        acquire;
    logic        ibar_apply;
    logic        early_ok;
    logic        late_ok;
    logic        ssb_hit;
    logic        ssb_lost;
    logic        ssb_accept;

    // the PSS pulse comes with sample 0 of the SSB symbol, so the timer
    // has to be told in the same cycle
    assign acquire    = (state_q == WAIT_FOR_SSB) && n_id_2_valid_i;
    assign ibar_apply = (state_q == WAIT_FOR_IBAR) && ibar_valid_i;

    // in case A the symbol before an SSB always has the short CP
    assign early_ok = sample_cnt_i >= 8'(FFT_LEN + CP2_LEN - SSB_TOL);
    assign late_ok  = sample_cnt_i <= 8'(SSB_TOL);

    // crossed_q tells whether the expected symbol boundary has already passed
    assign ssb_hit  = n_id_2_valid_i && find_win_q && (crossed_q ? late_ok : early_ok);
    assign ssb_lost = find_win_q && crossed_q && !late_ok;

    assign ssb_accept = acquire || ((state_q == WAIT_FOR_IBAR) && n_id_2_valid_i) || ssb_hit;

    assign cmd_o = '{acquire: acquire, ibar_adv: ibar_i, ibar_apply: ibar_apply};

    // the sample that triggers acquisition still carries a stale tag
    assign gate_o  = (state_q != WAIT_FOR_SSB) && !ssb_lost;
    assign state_o = state_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q     <= WAIT_FOR_SSB;
            find_win_q  <= 1'b0;
            crossed_q   <= 1'b0;
            ssb_start_o <= 1'b0;
        end else begin
            ssb_start_o <= ssb_accept;
            case (state_q)
                WAIT_FOR_SSB: begin
                    if (acquire) begin
                        state_q <= WAIT_FOR_IBAR;
                    end
                end
                WAIT_FOR_IBAR: begin
                    if (ibar_apply) begin
                        state_q <= SYNCED;
                    end
                end
                SYNCED: begin
                    if (ssb_lost) begin
                        state_q    <= WAIT_FOR_SSB;
                        find_win_q <= 1'b0;
                        crossed_q  <= 1'b0;
                    end else if (ssb_hit) begin
                        find_win_q <= 1'b0;
                        crossed_q  <= 1'b0;
                    end else if (find_win_q) begin
                        if (sym_end_i) begin
                            crossed_q <= 1'b1;
                        end
                    end else if (ssb_due_i && (sample_cnt_i == 8'd0)) begin
                        // open at the start of the symbol that precedes the SSB
                        find_win_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= WAIT_FOR_SSB;
                end
            endcase
        end
    end

    state_legal_a : assert property (@(posedge clk_i) disable iff (!reset_ni)
        state_q inside {WAIT_FOR_SSB, WAIT_FOR_IBAR, SYNCED});

    win_synced_a : assert property (@(posedge clk_i) disable iff (!reset_ni)
        find_win_q |-> (state_q == SYNCED));

endmodule

`default_nettype wire

// File: nr_sync_pkg.sv
`default_nettype none

package nr_sync_pkg;

    // scaled numerology so the design can be simulated in reasonable time
    localparam int FFT_LEN = 64;
    localparam int CP1_LEN = 5;
    localparam int CP2_LEN = 4;

    localparam int SYM_PER_SF   = 14;
    localparam int SF_PER_FRAME = 20;
    localparam int SFN_MAX      = 1024;

    // one SSB period, counted in symbols and in valid samples
    localparam int SYMS_BTWN_SSB      = 280;
    localparam int SSB_PERIOD_SAMPLES = 19080;

    // PSS detector wake-up margin and late tolerance, in valid samples
    localparam int PSS_EARLY = 64;
    localparam int PSS_LATE  = 64;

    // accepted misalignment of a re-detected SSB
    localparam int SSB_TOL = 2;

    localparam int IQ_W = 32;

    typedef logic [IQ_W-1:0] iq_sample_t;

    typedef struct packed {
        logic [9:0] sfn;
        logic [4:0] subframe;
        logic [3:0] symbol;
        logic [2:0] cp_len;
    } symbol_tag_t;

    typedef struct packed {
        iq_sample_t  data;
        symbol_tag_t tag;
        logic        last;
    } out_beat_t;

    typedef enum logic [1:0] {
        WAIT_FOR_SSB  = 2'd0,
        WAIT_FOR_IBAR = 2'd1,
        SYNCED        = 2'd2
    } sync_state_e;

    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FIND   = 2'd1,
        PAUSE  = 2'd2
    } pss_mode_e;

    typedef struct packed {
        logic       acquire;
        logic [1:0] ibar_adv;
        logic       ibar_apply;
    } timer_cmd_t;

endpackage

`default_nettype wire
